//--- hdl/cpuPkg.sv
package cpuPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [4:0] regIdx_t;   // Register index, 32 entries
    typedef logic [3:0] aluOp_t;    // Operation class from main decoder
    typedef logic [3:0] aluCtrl_t;  // Final ALU control code

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes, instr[31:26]
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] opRType    = 6'b000000;
    localparam logic [5:0] opRegImm   = 6'b000001;  // bltz / bgez, picked by rt
    localparam logic [5:0] opJ        = 6'b000010;
    localparam logic [5:0] opJal      = 6'b000011;
    localparam logic [5:0] opBeq      = 6'b000100;
    localparam logic [5:0] opBne      = 6'b000101;
    localparam logic [5:0] opBlez     = 6'b000110;
    localparam logic [5:0] opBgtz     = 6'b000111;
    localparam logic [5:0] opAddi     = 6'b001000;
    localparam logic [5:0] opSlti     = 6'b001010;
    localparam logic [5:0] opAndi     = 6'b001100;
    localparam logic [5:0] opOri      = 6'b001101;
    localparam logic [5:0] opXori     = 6'b001110;
    localparam logic [5:0] opSpecial2 = 6'b011100;  // mul lives here

    ////////////////////////////////////////////////////////////////////////////
    // Funct field, instr[5:0]
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr  = 6'b100101;
    localparam logic [5:0] fnNor = 6'b100111;
    localparam logic [5:0] fnXor = 6'b100110;
    localparam logic [5:0] fnSll = 6'b000000;
    localparam logic [5:0] fnSrl = 6'b000010;
    localparam logic [5:0] fnSlt = 6'b101010;
    localparam logic [5:0] fnMul = 6'b000010;  // Under opSpecial2 only

    ////////////////////////////////////////////////////////////////////////////
    // ALU operation classes
    ////////////////////////////////////////////////////////////////////////////

    localparam aluOp_t aluOpLoadAdd = 4'b0000;
    localparam aluOp_t aluOpAddi    = 4'b0001;
    localparam aluOp_t aluOpRType   = 4'b0010;  // Refined by funct
    localparam aluOp_t aluOpBgez    = 4'b0011;
    localparam aluOp_t aluOpBeq     = 4'b0100;
    localparam aluOp_t aluOpBne     = 4'b0101;
    localparam aluOp_t aluOpBgtz    = 4'b0110;
    localparam aluOp_t aluOpBlez    = 4'b0111;
    localparam aluOp_t aluOpBltz    = 4'b1000;
    localparam aluOp_t aluOpJump    = 4'b1001;
    localparam aluOp_t aluOpAndi    = 4'b1010;
    localparam aluOp_t aluOpOri     = 4'b1011;
    localparam aluOp_t aluOpXori    = 4'b1100;
    localparam aluOp_t aluOpSlti    = 4'b1101;
    localparam aluOp_t aluOpMul     = 4'b1111;

    // ALU control codes
    localparam aluCtrl_t aluPass = 4'b0000;
    localparam aluCtrl_t aluAdd  = 4'b0001;
    localparam aluCtrl_t aluSub  = 4'b0010;  // Also the beq compare
    localparam aluCtrl_t aluMul  = 4'b0011;
    localparam aluCtrl_t aluGez  = 4'b0100;
    localparam aluCtrl_t aluNe   = 4'b0101;
    localparam aluCtrl_t aluGtz  = 4'b0110;
    localparam aluCtrl_t aluLez  = 4'b0111;
    localparam aluCtrl_t aluSlt  = 4'b1000;  // slt, slti and bltz
    localparam aluCtrl_t aluAnd  = 4'b1010;
    localparam aluCtrl_t aluOr   = 4'b1011;
    localparam aluCtrl_t aluNor  = 4'b1100;
    localparam aluCtrl_t aluXor  = 4'b1101;
    localparam aluCtrl_t aluSll  = 4'b1110;
    localparam aluCtrl_t aluSrl  = 4'b1111;

    // Immediate extension modes
    localparam logic [1:0] immNone   = 2'b00;  // Second operand from rt
    localparam logic [1:0] immSigned = 2'b01;
    localparam logic [1:0] immZero   = 2'b10;

endpackage

//--- hdl/mainDecoder.sv
`timescale 1ns/1ps

module mainDecoder import cpuPkg::*; (
    input  logic [31:0] instr,
    output aluOp_t      aluOp,
    output logic [1:0]  immMode,
    output logic        wbEn,
    output regIdx_t     wbDest,
    output logic        isBranch,
    output logic        isJump,
    output logic        illegal
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regIdx_t    rt;
    regIdx_t    rd;
    logic       rTypeOk;  // Funct is one of the supported R-type ops

    // Instruction fields
    assign opcode = instr[31:26];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = instr[5:0];

    // Supported R-type funct values
    always_comb begin
        case (funct)
            fnAdd, fnSub, fnAnd, fnOr, fnNor,
            fnXor, fnSll, fnSrl, fnSlt: rTypeOk = 1'b1;
            default:                    rTypeOk = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // Defaults, no write, no flags
        aluOp    = aluOpLoadAdd;
        immMode  = immNone;
        wbEn     = 1'b0;
        wbDest   = rd;
        isBranch = 1'b0;
        isJump   = 1'b0;
        illegal  = 1'b0;

        case (opcode)
            opRType: begin
                aluOp   = aluOpRType;
                wbEn    = rTypeOk;
                illegal = !rTypeOk;
            end
            opSpecial2: begin
                aluOp   = aluOpMul;
                wbEn    = (funct == fnMul);  // Only mul is supported here
                illegal = (funct != fnMul);
            end

            // Branches, flag only
            opRegImm: begin
                aluOp    = rt[0] ? aluOpBgez : aluOpBltz;
                isBranch = 1'b1;
            end
            opBeq: begin
                aluOp    = aluOpBeq;
                isBranch = 1'b1;
            end
            opBne: begin
                aluOp    = aluOpBne;
                isBranch = 1'b1;
            end
            opBlez: begin
                aluOp    = aluOpBlez;
                isBranch = 1'b1;
            end
            opBgtz: begin
                aluOp    = aluOpBgtz;
                isBranch = 1'b1;
            end

            // j and jal report the jump, link not modelled
            opJ, opJal: begin
                aluOp  = aluOpJump;
                isJump = 1'b1;
            end

            // Immediate ALU forms write rt
            opAddi: begin
                aluOp   = aluOpAddi;
                immMode = immSigned;
                wbEn    = 1'b1;
                wbDest  = rt;
            end
            opSlti: begin
                aluOp   = aluOpSlti;
                immMode = immSigned;
                wbEn    = 1'b1;
                wbDest  = rt;
            end
            opAndi: begin
                aluOp   = aluOpAndi;
                immMode = immZero;
                wbEn    = 1'b1;
                wbDest  = rt;
            end
            opOri: begin
                aluOp   = aluOpOri;
                immMode = immZero;
                wbEn    = 1'b1;
                wbDest  = rt;
            end
            opXori: begin
                aluOp   = aluOpXori;
                immMode = immZero;
                wbEn    = 1'b1;
                wbDest  = rt;
            end
            default: illegal = 1'b1;  // Loads, stores, anything unknown
        endcase
    end

endmodule

//--- hdl/aluControl.sv
`timescale 1ns/1ps

module aluControl import cpuPkg::*; (
    input  aluOp_t     aluOp,
    input  logic [5:0] funct,
    output aluCtrl_t   aluCtrl
);

    aluCtrl_t rTypeCtrl;  // Code picked by funct

    ////////////////////////////////////////////////////////////////////////////
    // R-type funct decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (funct)
            fnAdd:   rTypeCtrl = aluAdd;
            fnSub:   rTypeCtrl = aluSub;
            fnAnd:   rTypeCtrl = aluAnd;
            fnOr:    rTypeCtrl = aluOr;
            fnNor:   rTypeCtrl = aluNor;
            fnXor:   rTypeCtrl = aluXor;
            fnSll:   rTypeCtrl = aluSll;
            fnSrl:   rTypeCtrl = aluSrl;
            fnSlt:   rTypeCtrl = aluSlt;
            default: rTypeCtrl = aluPass;  // Unsupported funct
        endcase
    end

    // Class to control code
    always_comb begin
        case (aluOp)
            aluOpLoadAdd: aluCtrl = aluAdd;     // Address style add
            aluOpAddi:    aluCtrl = aluAdd;
            aluOpRType:   aluCtrl = rTypeCtrl;

            // Branch compares
            aluOpBgez:    aluCtrl = aluGez;
            aluOpBeq:     aluCtrl = aluSub;     // Equal tested on a - b
            aluOpBne:     aluCtrl = aluNe;
            aluOpBgtz:    aluCtrl = aluGtz;
            aluOpBlez:    aluCtrl = aluLez;
            aluOpBltz:    aluCtrl = aluSlt;     // Sign of rs

            aluOpJump:    aluCtrl = aluPass;    // Nothing to compute

            // Immediate logic and compare
            aluOpAndi:    aluCtrl = aluAnd;
            aluOpOri:     aluCtrl = aluOr;
            aluOpXori:    aluCtrl = aluXor;
            aluOpSlti:    aluCtrl = aluSlt;

            aluOpMul:     aluCtrl = aluMul;
            default:      aluCtrl = aluPass;    // 1110 unused
        endcase
    end

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; #(
    parameter int dataWidth = 32
) (
    input  aluCtrl_t               aluCtrl,
    input  logic [dataWidth-1:0]   a,
    input  logic [dataWidth-1:0]   b,
    input  logic [4:0]             shamt,
    output logic [dataWidth-1:0]   result,
    output logic                   cond
);

    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;
    logic [dataWidth-1:0] prod;     // Low half of the signed product
    logic                 lessThan; // Signed a < b
    logic                 aNeg;
    logic                 aZero;
    logic                 abEqual;

    ////////////////////////////////////////////////////////////////////////////
    // Shared arithmetic
    ////////////////////////////////////////////////////////////////////////////

    assign sum      = a + b;
    assign diff     = a - b;
    assign prod     = $signed(a) * $signed(b);  // Truncated to dataWidth
    assign lessThan = $signed(a) < $signed(b);

    // Sign and zero tests on a, for the branch compares
    assign aNeg    = a[dataWidth-1];
    assign aZero   = (a == '0);
    assign abEqual = (a == b);

    // Result mux
    always_comb begin
        case (aluCtrl)
            aluAdd:  result = sum;
            aluSub:  result = diff;
            aluMul:  result = prod;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluNor:  result = ~(a | b);
            aluXor:  result = a ^ b;
            aluSll:  result = b << shamt;  // Shifts act on rt
            aluSrl:  result = b >> shamt;  // Logical, zero fill
            aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
            default: result = '0;          // Pass and compare-only codes
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch condition
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (aluCtrl)
            aluNe:   cond = !abEqual;
            aluSub:  cond = abEqual;           // beq
            aluGez:  cond = !aNeg;
            aluGtz:  cond = !aNeg && !aZero;
            aluLez:  cond = aNeg || aZero;
            aluSlt:  cond = aNeg;              // bltz, a below zero
            default: cond = 1'b0;
        endcase
    end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile import cpuPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  regIdx_t              rdAddrA,
    input  regIdx_t              rdAddrB,
    output logic [dataWidth-1:0] rdDataA,
    output logic [dataWidth-1:0] rdDataB,
    input  logic                 wrEn,
    input  regIdx_t              wrAddr,
    input  logic [dataWidth-1:0] wrData
);

    logic [dataWidth-1:0] regs [32];

    // Write port, register zero never written
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Read ports, combinational
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

//--- hdl/execCore.sv
`timescale 1ns/1ps

module execCore import cpuPkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  logic [31:0]          instr,
    output logic                 resVal,
    output logic                 resWb,
    output logic                 branchTaken,
    output logic                 jumpTaken,
    output logic                 illegalInstr,
    output logic [dataWidth-1:0] resData,
    output regIdx_t              resDest
);

    // Decode outputs
    aluOp_t     aluOp;
    logic [1:0] immMode;
    logic       wbEn;
    regIdx_t    wbDest;
    logic       isBranch;
    logic       isJump;
    logic       illegal;
    aluCtrl_t   aluCtrl;

    // Datapath
    logic [dataWidth-1:0] rsData;
    logic [dataWidth-1:0] rtData;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;
    logic                 cond;
    logic                 regWrite;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    mainDecoder uDecoder (
        .instr   (instr),
        .aluOp   (aluOp),
        .immMode (immMode),
        .wbEn    (wbEn),
        .wbDest  (wbDest),
        .isBranch(isBranch),
        .isJump  (isJump),
        .illegal (illegal)
    );

    aluControl uAluCtrl (
        .aluOp  (aluOp),
        .funct  (instr[5:0]),
        .aluCtrl(aluCtrl)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    // Write lands on the same edge, next instruction sees it
    assign regWrite = instrValid && wbEn && (wbDest != '0);

    regFile #(.dataWidth(dataWidth)) uRegs (
        .clk    (clk),
        .rstN   (rstN),
        .rdAddrA(instr[25:21]),     // rs
        .rdAddrB(instr[20:16]),     // rt
        .rdDataA(rsData),
        .rdDataB(rtData),
        .wrEn   (regWrite),
        .wrAddr (wbDest),
        .wrData (aluResult)
    );

    // Second operand select
    always_comb begin
        case (immMode)
            immSigned: opB = {{(dataWidth-16){instr[15]}}, instr[15:0]};
            immZero:   opB = {{(dataWidth-16){1'b0}}, instr[15:0]};
            default:   opB = rtData;
        endcase
    end

    alu #(.dataWidth(dataWidth)) uAlu (
        .aluCtrl(aluCtrl),
        .a      (rsData),
        .b      (opB),
        .shamt  (instr[10:6]),
        .result (aluResult),
        .cond   (cond)
    );

    // Outcome register, one cycle after issue
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resVal       <= 1'b0;
            resWb        <= 1'b0;
            branchTaken  <= 1'b0;
            jumpTaken    <= 1'b0;
            illegalInstr <= 1'b0;
        end else begin
            resVal       <= instrValid;
            resWb        <= regWrite;                 // Low for rd zero
            branchTaken  <= instrValid && isBranch && cond;
            jumpTaken    <= instrValid && isJump;
            illegalInstr <= instrValid && illegal;
        end
    end

    // Payload, held between instructions
    always_ff @(posedge clk) begin
        if (instrValid) begin
            resData <= aluResult;
            resDest <= wbDest;
        end
    end

endmodule

//--- tests/execModel.svh
// Model copy of the architectural registers
logic [dataWidth-1:0] modelRegs [32];

// Expected outcome of the instruction issued last
logic                 expVal;
logic                 expWb;
logic                 expBranch;
logic                 expJump;
logic                 expIllegal;
logic                 expHasData;  // resData and resDest defined
logic [dataWidth-1:0] expData;
regIdx_t              expDest;

// Nothing issued this cycle
task automatic modelIdle();
    expVal     = 1'b0;
    expWb      = 1'b0;
    expBranch  = 1'b0;
    expJump    = 1'b0;
    expIllegal = 1'b0;
    expHasData = 1'b0;
    expData    = '0;
    expDest    = '0;
endtask

task automatic modelReset();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    modelIdle();
endtask

////////////////////////////////////////////////////////////////////////////
// One instruction, outcome and register update
////////////////////////////////////////////////////////////////////////////

task automatic modelIssue(input logic [31:0] w);
    logic [5:0]           fn;
    regIdx_t              rt;
    logic [dataWidth-1:0] rsV;
    logic [dataWidth-1:0] rtV;
    logic [dataWidth-1:0] sImm;
    logic [dataWidth-1:0] zImm;
    logic [dataWidth-1:0] res;
    logic                 writes;
    regIdx_t              dest;
    fn     = w[5:0];
    rt     = w[20:16];
    rsV    = modelRegs[w[25:21]];  // Register zero reads back zero
    rtV    = modelRegs[rt];
    sImm   = {{(dataWidth-16){w[15]}}, w[15:0]};
    zImm   = {{(dataWidth-16){1'b0}}, w[15:0]};
    res    = '0;
    writes = 1'b1;
    dest   = w[15:11];             // rd unless immediate form
    modelIdle();
    expVal = 1'b1;
    case (w[31:26])
        opRType: begin
            case (fn)
                fnAdd:   res = rsV + rtV;
                fnSub:   res = rsV - rtV;
                fnAnd:   res = rsV & rtV;
                fnOr:    res = rsV | rtV;
                fnNor:   res = ~(rsV | rtV);
                fnXor:   res = rsV ^ rtV;
                fnSll:   res = rtV << w[10:6];
                fnSrl:   res = rtV >> w[10:6];
                fnSlt:   res = ($signed(rsV) < $signed(rtV)) ? 1 : 0;
                default: writes = 1'b0;  // Unsupported funct
            endcase
        end
        opSpecial2: begin
            if (fn == fnMul) res = $signed(rsV) * $signed(rtV);  // Low half
            else writes = 1'b0;
        end
        opAddi:   res = rsV + sImm;
        opSlti:   res = ($signed(rsV) < $signed(sImm)) ? 1 : 0;
        opAndi:   res = rsV & zImm;
        opOri:    res = rsV | zImm;
        opXori:   res = rsV ^ zImm;
        default:  writes = 1'b0;
    endcase
    case (w[31:26])
        opAddi, opSlti, opAndi, opOri, opXori: dest = rt;
        opRType, opSpecial2: expIllegal = !writes;
        opBeq:    expBranch = (rsV == rtV);
        opBne:    expBranch = (rsV != rtV);
        opBlez:   expBranch = ($signed(rsV) <= 0);
        opBgtz:   expBranch = ($signed(rsV) > 0);
        opRegImm: expBranch = rt[0] ? ($signed(rsV) >= 0) : ($signed(rsV) < 0);
        opJ, opJal: expJump = 1'b1;
        default:  expIllegal = 1'b1;  // Loads, stores, unknown
    endcase
    if (writes) begin
        expHasData = 1'b1;
        expData    = res;
        expDest    = dest;
        expWb      = (dest != 0);
        if (dest != 0) modelRegs[dest] = res;
    end
endtask

//--- tests/execCoreTb.sv
`timescale 1ns/1ps

module execCoreTb import cpuPkg::*; ();

    localparam int dataWidth   = 32;
    localparam int resetCycles = 16;
    localparam int idleCycles  = 4;     // Quiet check after reset
    localparam int testSlots   = 2000;  // Issue slots, about 3/4 used
    localparam int cycleLimit  = resetCycles + idleCycles + testSlots + 100;

    // Encoding pools, picked by 6-bit slice
    localparam logic [53:0] rFunctSet =
        {fnAdd, fnSub, fnAnd, fnOr, fnNor, fnXor, fnSll, fnSrl, fnSlt};
    localparam logic [29:0] immOps    = {opAddi, opSlti, opAndi, opOri, opXori};
    localparam logic [29:0] branchOps = {opBeq, opBne, opBlez, opBgtz, opRegImm};
    localparam logic [23:0] badOps    = {6'b100011, 6'b101011, 6'b001001, 6'b001111};

    logic                 clk;
    logic                 rstN;
    logic                 instrValid;
    logic [31:0]          instr;
    logic                 resVal;
    logic                 resWb;
    logic                 branchTaken;
    logic                 jumpTaken;
    logic                 illegalInstr;
    logic [dataWidth-1:0] resData;
    regIdx_t              resDest;

    integer seed = 56073;
    int     cycleCount = 0;

    // Expectation now in the outcome register
    logic                 chkVal;
    logic                 chkWb;
    logic                 chkBranch;
    logic                 chkJump;
    logic                 chkIllegal;
    logic                 chkHasData;
    logic [dataWidth-1:0] chkData;
    regIdx_t              chkDest;

    `include "execModel.svh"

    execCore #(.dataWidth(dataWidth)) dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .resVal      (resVal),
        .resWb       (resWb),
        .branchTaken (branchTaken),
        .jumpTaken   (jumpTaken),
        .illegalInstr(illegalInstr),
        .resData     (resData),
        .resDest     (resDest)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Run did not finish within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkData(input string name, input logic [dataWidth-1:0] got,
                             input logic [dataWidth-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic checkDest(input string name, input regIdx_t got, input regIdx_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic checkOutcome();
        checkFlag("resVal", resVal, chkVal);
        checkFlag("resWb", resWb, chkWb);
        checkFlag("branchTaken", branchTaken, chkBranch);
        checkFlag("jumpTaken", jumpTaken, chkJump);
        checkFlag("illegalInstr", illegalInstr, chkIllegal);
        if (chkHasData) begin  // Only for instructions with a defined result
            checkData("resData", resData, chkData);
            checkDest("resDest", resDest, chkDest);
        end
    endtask

    // Model outcome moves into the DUT outcome register
    task automatic latchExpect();
        chkVal     = expVal;
        chkWb      = expWb;
        chkBranch  = expBranch;
        chkJump    = expJump;
        chkIllegal = expIllegal;
        chkHasData = expHasData;
        chkData    = expData;
        chkDest    = expDest;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Random instructions
    ////////////////////////////////////////////////////////////////////////////

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Mostly r1..r7 so results get reused
    function automatic regIdx_t pickReg();
        int r;
        r = randBelow(10);
        if (r == 0) return '0;
        if (r == 1) return regIdx_t'(randBelow(32));
        return regIdx_t'(1 + randBelow(7));
    endfunction

    task automatic genInstr(output logic [31:0] w);
        int          kind;
        regIdx_t     rs;
        regIdx_t     rt;
        logic [15:0] imm;
        kind = randBelow(20);
        rs   = pickReg();
        rt   = pickReg();
        imm  = $random(seed);
        if (kind < 6) begin
            w = {opRType, rs, rt, pickReg(), imm[4:0], rFunctSet[6*randBelow(9) +: 6]};
        end else if (kind == 6) begin
            w = {opSpecial2, rs, rt, pickReg(), 5'd0, fnMul};
        end else if (kind < 12) begin
            w = {immOps[6*randBelow(5) +: 6], rs, rt, imm};
        end else if (kind < 17) begin
            if (randBelow(4) == 0) rt = rs;  // Force equal operands now and then
            w = {branchOps[6*randBelow(5) +: 6], rs, rt, imm};
        end else if (kind == 17) begin
            w = {(randBelow(2) != 0) ? opJal : opJ, imm, imm[9:0]};
        end else if (kind == 18) begin
            w = {badOps[6*randBelow(4) +: 6], rs, rt, imm};
        end else begin
            // jr under R-type, madd under special2
            w = (randBelow(2) != 0) ? {opRType, rs, rt, pickReg(), 5'd0, 6'b001000}
                                    : {opSpecial2, rs, rt, pickReg(), 5'd0, 6'b000000};
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] w;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        modelReset();
        latchExpect();
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        repeat (idleCycles) begin  // All flags low, nothing issued
            @(negedge clk);
            checkOutcome();
        end
        for (int s = 0; s <= testSlots; s++) begin
            @(posedge clk);
            latchExpect();
            if (s < testSlots && randBelow(4) != 0) begin
                genInstr(w);
                instrValid <= 1'b1;
                instr      <= w;
                modelIssue(w);
            end else begin
                instrValid <= 1'b0;
                modelIdle();
            end
            @(negedge clk);  // Outcome of the previous slot is stable here
            checkOutcome();
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- list.f
+incdir+tests
hdl/cpuPkg.sv
hdl/mainDecoder.sv
hdl/aluControl.sv
hdl/alu.sv
hdl/regFile.sv
hdl/execCore.sv
tests/execCoreTb.sv
